/* filelist.f */
+incdir+verilog
verilog/fir_bus_pkg.sv
verilog/fir_dsp_pkg.sv
verilog/fir_reg_front.sv
verilog/fir_tap.sv
verilog/fir_accum.sv
verilog/fir_accel_top.sv
dv/fir_accel_props.sv
dv/fir_checker.sv
dv/tb_fir_accel.sv

/* Bender.yml */
package:
  name: fir_accel

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fir_bus_pkg.sv
      - verilog/fir_dsp_pkg.sv
      - verilog/fir_reg_front.sv
      - verilog/fir_tap.sv
      - verilog/fir_accum.sv
      - verilog/fir_accel_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/fir_accel_props.sv
      - dv/fir_checker.sv
      - dv/tb_fir_accel.sv

/* dv/tb_fir_accel.sv */
/*
 * Testbench for the FIR accelerator with seeded random register traffic.
 * Requests are driven 1 ns after the rising edge, one per cycle at most.
 * A watchdog ends the run if the stimulus overruns its cycle budget.
 */
`timescale 1ns/1ps
`include "fir_consts.svh"

module tb_fir_accel;
    import fir_bus_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_REGS       = 8;
    localparam int NUM_SLOTS      = 2000;
    localparam int DRAIN_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = NUM_REGS + NUM_SLOTS + DRAIN_CYCLES + RESET_CYCLES + 20;

    logic      tb_clk;
    logic      reset;
    reg_req_t  req;
    reg_rsp_t  rsp;
    int        mismatch_count;
    int        protocol_count;
    int        assert_count;

    fir_accel_top DUT (
        .tb_clk (tb_clk),
        .reset  (reset),
        .req    (req),
        .rsp    (rsp)
    );

    fir_checker u_checker (
        .tb_clk         (tb_clk),
        .reset          (reset),
        .req            (req),
        .rsp            (rsp),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count)
    );

    bind fir_accel_top fir_accel_props u_props (
        .tb_clk (tb_clk),
        .reset  (reset),
        .req    (req),
        .rsp    (rsp),
        .result (result)
    );

    // 8 ns clock
    initial
    begin
        tb_clk = 1'b0;
        forever #4 tb_clk = ~tb_clk;
    end

    // ******************************************************************
    // Stimulus helpers
    // ******************************************************************
    task automatic send(input logic write, input logic [`FIR_ADDR_W-1:0] addr,
                        input logic [`FIR_DATA_W-1:0] wdata);
        @(posedge tb_clk);
        #1;
        req.valid = 1'b1;
        req.write = write;
        req.addr  = addr;
        req.wdata = wdata;
    endtask

    task automatic idle();
        @(posedge tb_clk);
        #1;
        req = '0;
    endtask

    // Mostly near 0 or near full scale
    function automatic logic [`FIR_DATA_W-1:0] extreme_value();
        case ($urandom_range(3))
            0:       return 16'hFFFF - 16'($urandom_range(255));
            1:       return 16'($urandom_range(255));
            default: return 16'($urandom);
        endcase
    endfunction

    task automatic random_slot();
        int pick;
        pick = $urandom_range(99);
        if (pick < 12)
            idle();
        else if (pick < 50)
            send(1'b1, `FIR_ADDR_SAMPLE, extreme_value());
        else if (pick < 60)
            send(1'b1, `FIR_ADDR_COEF0 + 4'(2 * $urandom_range(3)), extreme_value());
        else if (pick < 65)
            send(1'b1, `FIR_ADDR_COEF_SET, 16'($urandom));
        else if (pick < 90)
            send(1'b0, 4'(2 * $urandom_range(7)), 16'($urandom));
        else if (pick < 95)
            send(1'b1, $urandom_range(1) ? `FIR_ADDR_STATUS : `FIR_ADDR_RESULT, 16'($urandom));
        else
            // Misaligned access, read or write
            send(1'($urandom_range(1)), 4'(2 * $urandom_range(7) + 1), 16'($urandom));
    endtask

    // ******************************************************************
    // Main sequence
    // ******************************************************************
    initial
    begin
        void'($urandom(51));
        reset = 1'b1;
        req   = '0;
        repeat (RESET_CYCLES) @(posedge tb_clk);
        #1;
        reset = 1'b0;
        // Every mapped register after reset
        for (int a = 0; a < NUM_REGS; a++)
            send(1'b0, 4'(2 * a), 16'h0000);
        for (int s = 0; s < NUM_SLOTS; s++)
            random_slot();
        idle();
        repeat (DRAIN_CYCLES) @(posedge tb_clk);
        #1;
        assert_count = DUT.u_props.assert_fails;
        $display("Summary: %0d mismatches, %0d protocol errors, %0d assertion failures",
                 mismatch_count, protocol_count, assert_count);
        if (mismatch_count == 0 && protocol_count == 0 && assert_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Watchdog on total cycles
    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge tb_clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* dv/fir_checker.sv */
/*
 * Reference model of the FIR register map and filter.
 * Watches only the bus ports and checks every response.
 * Results become visible three edges after the sample write edge.
 */
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_checker (
    input  logic                   tb_clk,
    input  logic                   reset,
    input  fir_bus_pkg::reg_req_t  req,
    input  fir_bus_pkg::reg_rsp_t  rsp,
    output int                     mismatch_count,
    output int                     protocol_count
);
    import fir_bus_pkg::*;

    // Model registers
    logic [`FIR_DATA_W-1:0]  shadow_m [`FIR_NUM_TAPS];
    logic [`FIR_DATA_W-1:0]  active_m [`FIR_NUM_TAPS];
    logic [`FIR_DATA_W-1:0]  line_m   [`FIR_NUM_TAPS];
    logic [`FIR_DATA_W-1:0]  result_m;
    logic                    err_m;

    // Outputs in flight, due edge and {err, value}
    int                      due_q [$];
    logic [`FIR_DATA_W:0]    out_q [$];
    int                      cycle;

    // Response owed for the previous edge
    logic                    rsp_expected;
    logic                    exp_err;
    logic                    exp_check_data;
    logic [`FIR_DATA_W-1:0]  exp_rdata;
    string                   exp_name;

    initial
    begin
        mismatch_count = 0;
        protocol_count = 0;
    end

    // ******************************************************************
    // Filter rule and request naming
    // ******************************************************************
    function automatic logic [`FIR_DATA_W:0] filter_output();
        longint sum;
        longint prod;
        sum = 0;
        for (int k = 0; k < `FIR_NUM_TAPS; k++)
        begin
            prod = (longint'(line_m[k]) * longint'(active_m[k])) >>> `FIR_FRAC_BITS;
            // Even taps add, odd taps subtract
            if (k % 2 == 0)
                sum = sum + prod;
            else
                sum = sum - prod;
        end
        if (sum < 0)
            return {1'b1, 16'h0000};
        if (sum > 65535)
            return {1'b1, 16'hFFFF};
        return {1'b0, sum[`FIR_DATA_W-1:0]};
    endfunction

    function automatic string request_name(reg_req_t r);
        string kind;
        kind = r.write ? "write" : "read";
        if (r.addr[0])
            return $sformatf("%s odd address %0d", kind, r.addr);
        case (r.addr)
            `FIR_ADDR_STATUS:   return {kind, " STATUS"};
            `FIR_ADDR_RESULT:   return {kind, " RESULT"};
            `FIR_ADDR_SAMPLE:   return {kind, " SAMPLE"};
            `FIR_ADDR_COEF_SET: return {kind, " COEF_SET"};
            default:            return $sformatf("%s COEF%0d", kind, (r.addr - 6) / 2);
        endcase
    endfunction

    // ******************************************************************
    // Per-edge model update
    // ******************************************************************
    task automatic clear_model();
        for (int k = 0; k < `FIR_NUM_TAPS; k++)
        begin
            shadow_m[k] = '0;
            active_m[k] = '0;
            line_m[k]   = '0;
        end
        result_m     = '0;
        err_m        = 1'b0;
        cycle        = 0;
        rsp_expected = 1'b0;
        due_q.delete();
        out_q.delete();
    endtask

    task automatic check_response();
        if (rsp_expected && !rsp.valid)
        begin
            protocol_count++;
            $display("Missing response to %s at cycle %0d", exp_name, cycle);
        end
        else if (!rsp_expected && rsp.valid)
        begin
            protocol_count++;
            $display("Extra response with no request at cycle %0d", cycle);
        end
        else if (rsp_expected && rsp.err !== exp_err)
        begin
            mismatch_count++;
            $display("Mismatch %s err: expected %0d actual %0d", exp_name, exp_err, rsp.err);
        end
        else if (rsp_expected && exp_check_data && rsp.rdata !== exp_rdata)
        begin
            mismatch_count++;
            $display("Mismatch %s rdata: expected 0x%04h actual 0x%04h",
                     exp_name, exp_rdata, rsp.rdata);
        end
    endtask

    task automatic apply_request();
        logic [`FIR_DATA_W-1:0] data;
        int                     idx;
        data           = '0;
        idx            = (int'(req.addr) - 6) / 2;
        exp_name       = request_name(req);
        exp_err        = req.addr[0] ||
                         (req.write && (req.addr == `FIR_ADDR_STATUS ||
                                        req.addr == `FIR_ADDR_RESULT));
        exp_check_data = !req.write && !exp_err;
        if (!exp_err && !req.write)
        begin
            if (req.addr == `FIR_ADDR_STATUS)
            begin
                data[`FIR_STAT_BUSY] = (due_q.size() != 0);
                data[`FIR_STAT_ERR]  = err_m;
            end
            else if (req.addr == `FIR_ADDR_RESULT)
                data = result_m;
            else if (req.addr == `FIR_ADDR_SAMPLE)
                data = line_m[0];
            else if (req.addr != `FIR_ADDR_COEF_SET)
                data = shadow_m[idx];
        end
        else if (!exp_err)
        begin
            if (req.addr == `FIR_ADDR_SAMPLE)
            begin
                for (int k = `FIR_NUM_TAPS - 1; k > 0; k--)
                    line_m[k] = line_m[k-1];
                line_m[0] = req.wdata;
                // Active bank as issued, result three edges later
                due_q.push_back(cycle + 3);
                out_q.push_back(filter_output());
            end
            else if (req.addr == `FIR_ADDR_COEF_SET)
            begin
                for (int k = 0; k < `FIR_NUM_TAPS; k++)
                    active_m[k] = shadow_m[k];
            end
            else
                shadow_m[idx] = req.wdata;
        end
        exp_rdata = data;
    endtask

    always @(posedge tb_clk)
    begin
        if (reset)
            clear_model();
        else
        begin
            cycle++;
            check_response();
            // Results due now are already readable
            while (due_q.size() > 0 && due_q[0] <= cycle)
            begin
                {err_m, result_m} = out_q.pop_front();
                void'(due_q.pop_front());
            end
            rsp_expected = req.valid;
            if (req.valid)
                apply_request();
        end
    end

endmodule

/* dv/fir_accel_props.sv */
/*
 * Bound protocol checks for the FIR accelerator top level.
 * Attach to fir_accel_top, whose internal result strobe is observed.
 * Failures are counted in assert_fails for the closing summary.
 */
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_accel_props (
    input  logic                      tb_clk,
    input  logic                      reset,
    input  fir_bus_pkg::reg_req_t     req,
    input  fir_bus_pkg::reg_rsp_t     rsp,
    input  fir_dsp_pkg::fir_result_t  result
);
    import fir_bus_pkg::*;

    int   assert_fails = 0;
    logic sample_wr;

    // Accepted sample write, starts one filter output
    assign sample_wr = req.valid && req.write && (req.addr == `FIR_ADDR_SAMPLE);

    // ******************************************************************
    // Bus strobe timing
    // ******************************************************************
    rsp_after_req: assert property (@(posedge tb_clk) disable iff (reset)
        req.valid |=> rsp.valid)
    else
    begin
        $error("Response missing one cycle after a request");
        assert_fails++;
    end

    no_rsp_without_req: assert property (@(posedge tb_clk) disable iff (reset)
        !req.valid |=> !rsp.valid)
    else
    begin
        $error("Response seen without a request one cycle earlier");
        assert_fails++;
    end

    // ******************************************************************
    // Result strobe timing
    // ******************************************************************
    result_after_sample: assert property (@(posedge tb_clk) disable iff (reset)
        sample_wr |-> ##3 result.valid)
    else
    begin
        $error("Result strobe missing three cycles after a sample write");
        assert_fails++;
    end

    no_stray_result: assert property (@(posedge tb_clk) disable iff (reset)
        result.valid |-> $past(sample_wr, 3))
    else
    begin
        $error("Result strobe without a sample write three cycles earlier");
        assert_fails++;
    end

    // Strobes cleared while reset is held
    quiet_in_reset: assert property (@(posedge tb_clk)
        reset |=> (!rsp.valid && !result.valid))
    else
    begin
        $error("Strobe active during reset");
        assert_fails++;
    end

endmodule

/* verilog/fir_accel_top.sv */
/*
 * Top level of the memory-mapped four-tap FIR accelerator.
 * A sample write gives a result three cycles after it is accepted.
 * Even taps add their product, odd taps subtract it.
 */
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_accel_top (
    input  logic                   tb_clk,
    input  logic                   reset,
    input  fir_bus_pkg::reg_req_t  req,
    output fir_bus_pkg::reg_rsp_t  rsp
);
    import fir_dsp_pkg::*;

    tap_in_t                    tap_in  [`FIR_NUM_TAPS];
    product_t                   product [`FIR_NUM_TAPS];
    logic [`FIR_NUM_TAPS-1:0]   tap_valid;
    fir_result_t                result;

    // ******************************************************************
    // Register front end
    // ******************************************************************
    fir_reg_front u_reg_front (
        .tb_clk (tb_clk),
        .reset  (reset),
        .req    (req),
        .rsp    (rsp),
        .tap_in (tap_in),
        .result (result)
    );

    // ******************************************************************
    // Taps, sign alternates with index
    // ******************************************************************
    for (genvar k = 0; k < `FIR_NUM_TAPS; k++)
    begin : g_tap
        fir_tap #(
            .TAP_NEGATE (k % 2)
        ) u_tap (
            .tb_clk        (tb_clk),
            .reset         (reset),
            .tap_in        (tap_in[k]),
            .product       (product[k]),
            .product_valid (tap_valid[k])
        );
    end

    // All taps share one valid, tap 0 stands for them
    fir_accum u_accum (
        .tb_clk        (tb_clk),
        .reset         (reset),
        .product       (product),
        .product_valid (tap_valid[0]),
        .result        (result)
    );

endmodule

/* verilog/fir_accum.sv */
/*
 * Sums the tap products and clamps to the unsigned 16-bit range.
 * err marks an output that was clamped at either end.
 * Products must all be valid in the same cycle as product_valid.
 */
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_accum (
    input  logic                      tb_clk,
    input  logic                      reset,
    input  fir_dsp_pkg::product_t     product [`FIR_NUM_TAPS],
    input  logic                      product_valid,
    output fir_dsp_pkg::fir_result_t  result
);
    import fir_dsp_pkg::*;

    // Largest output value
    localparam acc_t SAT_MAX = acc_t'((1 << `FIR_DATA_W) - 1);

    acc_t                    sum;
    logic [`FIR_DATA_W-1:0]  sat_value;
    logic                    sat_err;

    // Registered output
    logic                    result_valid_q;
    logic                    result_err_q;
    logic [`FIR_DATA_W-1:0]  result_value_q;

    // Sign-extended sum of all taps
    always_comb
    begin
        sum = '0;
        for (int k = 0; k < `FIR_NUM_TAPS; k++)
            sum = sum + acc_t'(product[k]);
    end

    // Clamp to 0 .. 65535
    always_comb
    begin
        sat_err   = 1'b0;
        sat_value = sum[`FIR_DATA_W-1:0];
        if (sum < 0)
        begin
            sat_value = '0;
            sat_err   = 1'b1;
        end
        else if (sum > SAT_MAX)
        begin
            sat_value = '1;
            sat_err   = 1'b1;
        end
    end

    always_ff @(posedge tb_clk)
    begin
        if (reset)
            result_valid_q <= 1'b0;
        else
            result_valid_q <= product_valid;
    end

    // Value and flag only change with a new output
    always_ff @(posedge tb_clk)
    begin
        if (product_valid)
        begin
            result_value_q <= sat_value;
            result_err_q   <= sat_err;
        end
    end

    assign result = '{valid: result_valid_q, err: result_err_q, value: result_value_q};

endmodule

/* verilog/fir_tap.sv */
/*
 * One FIR tap: sample times Q1.15 coefficient, fraction bits dropped.
 * TAP_NEGATE set gives the subtracting taps of the filter.
 * Latency of one cycle, product held between valid strobes.
 */
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_tap #(
    parameter int TAP_NEGATE = 0
) (
    input  logic                   tb_clk,
    input  logic                   reset,
    input  fir_dsp_pkg::tap_in_t   tap_in,
    output fir_dsp_pkg::product_t  product,
    output logic                   product_valid
);
    import fir_dsp_pkg::*;

    logic [2*`FIR_DATA_W-1:0]  full_prod;
    logic [`FIR_PROD_W-1:0]    scaled;
    product_t                  product_d;

    // Full unsigned 32-bit product
    assign full_prod = tap_in.sample * tap_in.coeff;
    // Drop fraction bits, top bits are always zero
    assign scaled    = `FIR_PROD_W'(full_prod >> `FIR_FRAC_BITS);
    // Sign of this tap
    assign product_d = (TAP_NEGATE != 0) ? -product_t'(scaled) : product_t'(scaled);

    always_ff @(posedge tb_clk)
    begin
        if (reset)
            product_valid <= 1'b0;
        else
            product_valid <= tap_in.valid;
    end

    always_ff @(posedge tb_clk)
    begin
        if (tap_in.valid)
            product <= product_d;
    end

endmodule

/* verilog/fir_reg_front.sv */
/*
 * Register front end of the FIR accelerator.
 * Odd addresses and writes to STATUS or RESULT are rejected with err.
 * RESULT and STATUS reads see a result in the same cycle it arrives.
 */
`timescale 1ns/1ps
`include "fir_consts.svh"

module fir_reg_front (
    input  logic                      tb_clk,
    input  logic                      reset,
    input  fir_bus_pkg::reg_req_t     req,
    output fir_bus_pkg::reg_rsp_t     rsp,
    output fir_dsp_pkg::tap_in_t      tap_in [`FIR_NUM_TAPS],
    input  fir_dsp_pkg::fir_result_t  result
);
    import fir_bus_pkg::*;
    import fir_dsp_pkg::*;

    localparam int CNT_W = $clog2(`FIR_NUM_TAPS);
    localparam int IDX_W = $clog2(`FIR_NUM_TAPS);

    // Coefficient banks and delay line
    coeff_t                  shadow_coef [`FIR_NUM_TAPS];
    coeff_t                  active_coef [`FIR_NUM_TAPS];
    sample_t                 delay_line  [`FIR_NUM_TAPS];
    logic                    issue_valid;

    // Status and last output
    logic [CNT_W-1:0]        inflight;
    logic [CNT_W-1:0]        inflight_now;
    logic [`FIR_DATA_W-1:0]  result_q;
    logic                    err_q;
    logic [`FIR_DATA_W-1:0]  result_now;
    logic                    err_now;
    logic                    busy_now;

    // Decode
    logic                    is_status;
    logic                    is_result;
    logic                    is_sample;
    logic                    is_coef;
    logic                    is_coef_set;
    logic                    access_err;
    logic [`FIR_ADDR_W-1:0]  coef_off;
    logic [IDX_W-1:0]        coef_idx;
    logic                    wr_ok;
    reg_rsp_t                rsp_d;

    // ******************************************************************
    // Address decode
    // ******************************************************************
    assign is_status   = (req.addr == `FIR_ADDR_STATUS);
    assign is_result   = (req.addr == `FIR_ADDR_RESULT);
    assign is_sample   = (req.addr == `FIR_ADDR_SAMPLE);
    assign is_coef_set = (req.addr == `FIR_ADDR_COEF_SET);
    assign is_coef     = (req.addr >= `FIR_ADDR_COEF0) && (req.addr < `FIR_ADDR_COEF_SET);

    // Two bytes per coefficient register
    assign coef_off    = req.addr - `FIR_ADDR_COEF0;
    assign coef_idx    = coef_off[IDX_W:1];

    // Misaligned or read-only target
    assign access_err  = req.addr[0] | (req.write & (is_status | is_result));
    assign wr_ok       = req.valid & req.write & ~access_err;

    // Bypass a result arriving this cycle
    assign result_now   = result.valid ? result.value : result_q;
    assign err_now      = result.valid ? result.err : err_q;
    assign inflight_now = inflight - CNT_W'(result.valid);
    assign busy_now     = |inflight_now;

    // ******************************************************************
    // Read data and response
    // ******************************************************************
    always_comb
    begin
        rsp_d       = '0;
        rsp_d.valid = req.valid;
        rsp_d.err   = req.valid & access_err;
        if (req.valid && !req.write && !access_err)
        begin
            if (is_status)
            begin
                rsp_d.rdata[`FIR_STAT_BUSY] = busy_now;
                rsp_d.rdata[`FIR_STAT_ERR]  = err_now;
            end
            else if (is_result)
                rsp_d.rdata = result_now;
            else if (is_sample)
                rsp_d.rdata = delay_line[0];
            else if (is_coef)
                rsp_d.rdata = shadow_coef[coef_idx];
            // COEF_SET reads back as zero
        end
    end

    always_ff @(posedge tb_clk)
    begin
        if (reset)
        begin
            rsp         <= '0;
            issue_valid <= 1'b0;
            inflight    <= '0;
            result_q    <= '0;
            err_q       <= 1'b0;
            for (int k = 0; k < `FIR_NUM_TAPS; k++)
            begin
                shadow_coef[k] <= '0;
                active_coef[k] <= '0;
                delay_line[k]  <= '0;
            end
        end
        else
        begin
            rsp         <= rsp_d;
            issue_valid <= wr_ok & is_sample;
            inflight    <= inflight_now + CNT_W'(wr_ok & is_sample);
            if (result.valid)
            begin
                result_q <= result.value;
                err_q    <= result.err;
            end
            // Newest sample enters at stage 0
            if (wr_ok && is_sample)
            begin
                delay_line[0] <= req.wdata;
                for (int k = 1; k < `FIR_NUM_TAPS; k++)
                    delay_line[k] <= delay_line[k-1];
            end
            if (wr_ok && is_coef)
                shadow_coef[coef_idx] <= req.wdata;
            // Confirm copies the whole shadow bank
            if (wr_ok && is_coef_set)
                active_coef <= shadow_coef;
        end
    end

    // One operand pair per tap, shared valid
    always_comb
    begin
        for (int k = 0; k < `FIR_NUM_TAPS; k++)
        begin
            tap_in[k].valid  = issue_valid;
            tap_in[k].sample = delay_line[k];
            tap_in[k].coeff  = active_coef[k];
        end
    end

endmodule

/* verilog/fir_dsp_pkg.sv */
/*
 * Datapath types of the FIR filter.
 * Samples are unsigned 16 bit, coefficients unsigned Q1.15.
 * Product and accumulator are signed and wide enough for four taps.
 */
`include "fir_consts.svh"

package fir_dsp_pkg;

    typedef logic        [`FIR_DATA_W-1:0] sample_t;
    typedef logic        [`FIR_DATA_W-1:0] coeff_t;
    // Shifted tap product, sign applied
    typedef logic signed [`FIR_PROD_W-1:0] product_t;
    typedef logic signed [`FIR_ACC_W-1:0]  acc_t;

    // Filter output after saturation
    typedef struct packed {
        logic                    valid;
        logic                    err;
        logic [`FIR_DATA_W-1:0]  value;
    } fir_result_t;

    // Operands handed to one tap
    typedef struct packed {
        logic    valid;
        sample_t sample;
        coeff_t  coeff;
    } tap_in_t;

endpackage

/* verilog/fir_bus_pkg.sv */
/*
 * Register bus request and response types.
 * One request strobe per cycle, no back-pressure.
 * Each request is answered by exactly one response a cycle later.
 */
`include "fir_consts.svh"

package fir_bus_pkg;

    // Request from the bus side, valid for a single cycle
    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [`FIR_ADDR_W-1:0]  addr;
        logic [`FIR_DATA_W-1:0]  wdata;
    } reg_req_t;

    // Registered response, err set for a rejected access
    typedef struct packed {
        logic                    valid;
        logic                    err;
        logic [`FIR_DATA_W-1:0]  rdata;
    } reg_rsp_t;

endpackage

/* verilog/fir_consts.svh */
/*
 * Widths, tap count and register map of the four-tap FIR accelerator.
 * Addresses are byte addresses of 16-bit registers and must be even.
 * Product and accumulator widths assume four taps of 16-bit data.
 */
`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

// Datapath sizing
`define FIR_NUM_TAPS      4
`define FIR_DATA_W        16
`define FIR_ADDR_W        4
`define FIR_FRAC_BITS     15
`define FIR_PROD_W        18
`define FIR_ACC_W         20

// Register map
`define FIR_ADDR_STATUS   4'd0
`define FIR_ADDR_RESULT   4'd2
`define FIR_ADDR_SAMPLE   4'd4
`define FIR_ADDR_COEF0    4'd6
`define FIR_ADDR_COEF_SET 4'd14

// Status register bits
`define FIR_STAT_BUSY     0
`define FIR_STAT_ERR      1

`endif
